// File: verilog.f
+incdir+.
spectrum_pkg.sv
cpu_cycle_if.sv
page_state_if.sv
paging_ports.sv
joystick_port.sv
bus_sequencer.sv
zx_paging_top.sv
zx_paging_properties.sv
tb_zx_paging.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the paging core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
	--top-module tb_zx_paging -o sim_tb_zx_paging \
	&& ./obj_dir/sim_tb_zx_paging | tee /dev/stderr | grep -q "Test OK" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: tb_zx_paging.sv
// Paging core testbench
`include "spectrum_defs.svh"

module tb_zx_paging;
	timeunit 1ns;
	timeprecision 1ps;
	import spectrum_pkg::*;

	localparam int CLK_PERIOD     = 40;
	// Upper bound on bus cycles and resets, and clocks spent on each
	localparam int MAX_CYCLES     = 200;
	localparam int CLKS_PER_CYCLE = `ACK_LATENCY + 6;
	localparam int TIMEOUT_NS     = 2 * MAX_CYCLES * CLKS_PER_CYCLE * CLK_PERIOD;

	logic                   clk_sys = 1'b0;
	logic                   reset;
	machine_t               machine;
	logic                   bus_req;
	logic                   bus_ack;
	logic [`CPU_ADDR_W-1:0] bus_addr;
	logic [`CPU_DATA_W-1:0] bus_wdata;
	logic                   bus_wr;
	logic                   bus_io;
	logic [`CPU_DATA_W-1:0] bus_rdata;
	logic [`MEM_ADDR_W-1:0] mem_addr;
	logic                   mem_we;
	logic [`CPU_DATA_W-1:0] mem_rdata;
	logic [`JOY_W-1:0]      joy_0;
	logic [`JOY_W-1:0]      joy_1;
	logic [2:0]             joy_sel;
	logic [`KEY_ROW_W-1:0]  key_row;

	int seed = 54629;
	int checks = 0;
	int errors = 0;
	int checks_mark = 0;
	int errors_mark = 0;

	// Reference paging state
	machine_t   ref_mach;
	logic [7:0] ref_7ffd;
	logic [2:0] ref_1ffd;
	logic       ref_compat;

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// External memory data depends on every physical address bit
	function automatic logic [7:0] memory_byte(input logic [`MEM_ADDR_W-1:0] addr);
		return addr[7:0] ^ addr[15:8] ^ {3'b000, addr[20:16]};
	endfunction

	assign mem_rdata = memory_byte(mem_addr);

	zx_paging_top zx_paging_top_i (.*);

	// ========================================================================
	// Reference model
	// ========================================================================

	function automatic logic paging_blocked();
		return ref_mach == MACH_48 ||
			(ref_7ffd[5] && (ref_mach != MACH_P1024 || ref_compat));
	endfunction

	function automatic logic [1:0] expected_rom();
		case (ref_mach)
			MACH_48:    return 2'd1;
			MACH_PLUS3: return {ref_1ffd[2], ref_7ffd[4]};
			default:    return {1'b0, ref_7ffd[4]};
		endcase
	endfunction

	// Pentagon extended mode adds bit 5 and bits 7:6 above the 128K bank
	function automatic logic [5:0] expected_bank();
		if (ref_mach == MACH_P1024 && !ref_compat)
			return {ref_7ffd[5], ref_7ffd[7:6], ref_7ffd[2:0]};
		return {3'b000, ref_7ffd[2:0]};
	endfunction

	// Banks of 0000 4000 8000 C000 in each all-RAM layout
	function automatic logic [2:0] special_bank(input logic [1:0] cfg,
		input logic [1:0] region);
		logic [11:0] row;
		case (cfg)
			2'd0:    row = {3'd3, 3'd2, 3'd1, 3'd0};
			2'd1:    row = {3'd7, 3'd6, 3'd5, 3'd4};
			2'd2:    row = {3'd3, 3'd6, 3'd5, 3'd4};
			default: row = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
		return row[region * 3 +: 3];
	endfunction

	function automatic logic [`MEM_ADDR_W-1:0] expected_addr(input logic [15:0] addr);
		logic       is_rom;
		logic [5:0] bank;
		is_rom = 1'b0;
		if (ref_1ffd[0]) begin
			bank = {3'b000, special_bank(ref_1ffd[2:1], addr[15:14])};
		end else begin
			case (addr[15:14])
				2'd0: begin
					is_rom = 1'b1;
					bank   = {4'b0000, expected_rom()};
				end
				2'd1:    bank = 6'd5;
				2'd2:    bank = 6'd2;
				default: bank = expected_bank();
			endcase
		end
		return {is_rom, bank, addr[13:0]};
	endfunction

	// Stick bits are right 0, left 1, down 2, up 3, fire 4
	function automatic logic [7:0] expected_port(input logic [15:0] addr);
		logic [4:0] any;
		logic [4:0] press_60;
		logic [4:0] press_15;
		logic [4:0] mask;
		any = joy_0 | joy_1;
		if (addr[7:0] == 8'h1F)
			return (joy_sel == 3'd0) ? {3'b000, any} : 8'h00;
		if (addr[0])
			return 8'hFF;
		// Row 6-0 bits 4..0 are keys 6 7 8 9 0, row 1-5 bits 0..4 keys 1..5
		press_60 = 5'b00000;
		press_15 = 5'b00000;
		if (joy_sel[0])
			press_60 |= {joy_0[1], joy_0[0], joy_0[2], joy_0[3], joy_0[4]};
		if (joy_sel[1])
			press_15 |= {joy_1[4], joy_1[3], joy_1[2], joy_1[0], joy_1[1]};
		if (joy_sel[2]) begin
			// 5 left, 6 down, 7 up, 8 right, 0 fire
			press_60 |= {any[2], any[3], any[0], 1'b0, any[4]};
			press_15 |= {any[1], 4'b0000};
		end
		mask = 5'b11111;
		if (!addr[12])
			mask &= ~press_60;
		if (!addr[11])
			mask &= ~press_15;
		return {3'b111, key_row & mask};
	endfunction

	task automatic apply_port_write(input logic [15:0] addr, input logic [7:0] data);
		logic blocked;
		blocked = paging_blocked();
		if (addr == 16'h7FFD && !blocked)
			ref_7ffd = data;
		if (addr == 16'h1FFD && ref_mach == MACH_PLUS3 && !blocked)
			ref_1ffd = data[2:0];
		if (addr == 16'hEFF7 && ref_mach == MACH_P1024)
			ref_compat = data[2];
	endtask

	// ========================================================================
	// Checks and bus cycles
	// ========================================================================

	task automatic check_value(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("Fail %s: %s expected %0h, actual %0h", name, what, expected, actual);
		end
	endtask

	task automatic finish_test(input string name);
		$display("%s: %0d checks, %0d errors", name, checks - checks_mark,
			errors - errors_mark);
		checks_mark = checks;
		errors_mark = errors;
	endtask

	// Called on a falling edge
	task automatic reset_machine(input machine_t mach);
		machine = mach;
		reset   = 1'b1;
		repeat (2) @(negedge clk_sys);
		reset      = 1'b0;
		ref_mach   = mach;
		ref_7ffd   = 8'h00;
		ref_1ffd   = 3'b000;
		ref_compat = 1'b0;
		check_value("reset", "bus_ack", 32'(0), 32'(bus_ack));
	endtask

	task automatic bus_cycle(input string name, input logic [15:0] addr,
		input logic [7:0] wdata, input logic wr, input logic io);
		logic [`MEM_ADDR_W-1:0] exp_addr;
		logic [7:0]             exp_rdata;
		@(negedge clk_sys);
		bus_addr  = addr;
		bus_wdata = wdata;
		bus_wr    = wr;
		bus_io    = io;
		bus_req   = 1'b1;
		while (!bus_ack)
			@(negedge clk_sys);
		exp_addr  = expected_addr(addr);
		exp_rdata = io ? expected_port(addr) : memory_byte(exp_addr);
		if (!io)
			check_value(name, "mem_addr", 32'(exp_addr), 32'(mem_addr));
		check_value(name, "mem_we", 32'(wr && !io && !exp_addr[`MEM_ADDR_W-1]),
			32'(mem_we));
		if (!wr)
			check_value(name, "bus_rdata", 32'(exp_rdata), 32'(bus_rdata));
		bus_req = 1'b0;
		while (bus_ack)
			@(negedge clk_sys);
		if (io && wr)
			apply_port_write(addr, wdata);
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	initial begin
		int         i;
		int         r;
		logic [7:0] val;

		reset     = 1'b1;
		machine   = MACH_128;
		bus_req   = 1'b0;
		bus_addr  = '0;
		bus_wdata = '0;
		bus_wr    = 1'b0;
		bus_io    = 1'b0;
		joy_0     = '0;
		joy_1     = '0;
		joy_sel   = 3'd0;
		key_row   = 5'h1F;

		// 128K mapping
		reset_machine(MACH_128);
		bus_cycle("map_128", 16'hC000, 8'h00, 1'b0, 1'b0);
		for (i = 0; i < 4; i++) begin
			val = 8'($random(seed)) & 8'h1F;
			bus_cycle("map_128", 16'h7FFD, val, 1'b1, 1'b1);
			bus_cycle("map_128", 16'hC123, 8'h00, 1'b0, 1'b0);
			bus_cycle("map_128", 16'h4010, 8'h00, 1'b0, 1'b0);
			bus_cycle("map_128", 16'h8020, 8'h00, 1'b0, 1'b0);
			bus_cycle("map_128", 16'h0040, 8'h00, 1'b0, 1'b0);
			bus_cycle("map_128", 16'h0044, 8'h5A, 1'b1, 1'b0);
			bus_cycle("map_128", 16'hC044, 8'hA5, 1'b1, 1'b0);
		end
		finish_test("map_128");

		// Lock until reset, and 48K never pages
		bus_cycle("lock", 16'h7FFD, 8'h23, 1'b1, 1'b1);
		bus_cycle("lock", 16'hC000, 8'h00, 1'b0, 1'b0);
		bus_cycle("lock", 16'h7FFD, 8'h06, 1'b1, 1'b1);
		bus_cycle("lock", 16'hC001, 8'h00, 1'b0, 1'b0);
		reset_machine(MACH_128);
		bus_cycle("lock", 16'h7FFD, 8'h06, 1'b1, 1'b1);
		bus_cycle("lock", 16'hC002, 8'h00, 1'b0, 1'b0);
		reset_machine(MACH_48);
		bus_cycle("lock", 16'h7FFD, 8'h17, 1'b1, 1'b1);
		bus_cycle("lock", 16'hC003, 8'h00, 1'b0, 1'b0);
		bus_cycle("lock", 16'h0004, 8'h00, 1'b0, 1'b0);
		finish_test("lock");

		// Pentagon 1024 extended banks
		reset_machine(MACH_P1024);
		for (i = 0; i < 4; i++) begin
			val = 8'($random(seed));
			bus_cycle("p1024", 16'h7FFD, val, 1'b1, 1'b1);
			bus_cycle("p1024", 16'hC100, 8'h00, 1'b0, 1'b0);
		end
		bus_cycle("p1024", 16'hEFF7, 8'h04, 1'b1, 1'b1);
		bus_cycle("p1024", 16'hC101, 8'h00, 1'b0, 1'b0);
		bus_cycle("p1024", 16'h7FFD, 8'h26, 1'b1, 1'b1);
		bus_cycle("p1024", 16'h7FFD, 8'h01, 1'b1, 1'b1);
		bus_cycle("p1024", 16'hC102, 8'h00, 1'b0, 1'b0);
		bus_cycle("p1024", 16'hEFF7, 8'h00, 1'b1, 1'b1);
		bus_cycle("p1024", 16'h7FFD, 8'hE3, 1'b1, 1'b1);
		bus_cycle("p1024", 16'hC103, 8'h00, 1'b0, 1'b0);
		finish_test("p1024");

		// +3 all-RAM layouts
		reset_machine(MACH_PLUS3);
		for (i = 0; i < 4; i++) begin
			bus_cycle("plus3", 16'h1FFD, {5'b00000, 2'(i), 1'b1}, 1'b1, 1'b1);
			for (r = 0; r < 4; r++)
				bus_cycle("plus3", {2'(r), 14'h0123}, 8'h00, 1'b0, 1'b0);
			bus_cycle("plus3", 16'h0010, 8'h77, 1'b1, 1'b0);
		end
		bus_cycle("plus3", 16'h1FFD, 8'h04, 1'b1, 1'b1);
		bus_cycle("plus3", 16'h7FFD, 8'h10, 1'b1, 1'b1);
		bus_cycle("plus3", 16'h0020, 8'h00, 1'b0, 1'b0);
		bus_cycle("plus3", 16'h0021, 8'h33, 1'b1, 1'b0);
		bus_cycle("plus3", 16'hC022, 8'h00, 1'b0, 1'b0);
		finish_test("plus3");

		// Port reads, inputs change on a falling edge
		reset_machine(MACH_128);
		for (i = 0; i < 8; i++) begin
			joy_0   = 5'($random(seed));
			joy_1   = 5'($random(seed));
			joy_sel = (i < 2) ? 3'd0 : 3'($random(seed));
			key_row = 5'($random(seed));
			bus_cycle("ports", 16'hEFFE, 8'h00, 1'b0, 1'b1);
			bus_cycle("ports", 16'hF7FE, 8'h00, 1'b0, 1'b1);
			bus_cycle("ports", 16'hE7FE, 8'h00, 1'b0, 1'b1);
			bus_cycle("ports", 16'hFFFE, 8'h00, 1'b0, 1'b1);
			bus_cycle("ports", 16'h001F, 8'h00, 1'b0, 1'b1);
			bus_cycle("ports", 16'h00FF, 8'h00, 1'b0, 1'b1);
			bus_cycle("ports", 16'($random(seed)), 8'h00, 1'b0, 1'b0);
		end
		finish_test("ports");

		// Reset lands while a request is held and acknowledged
		@(negedge clk_sys);
		bus_addr = 16'h8000;
		bus_wr   = 1'b0;
		bus_io   = 1'b0;
		bus_req  = 1'b1;
		while (!bus_ack)
			@(negedge clk_sys);
		reset_machine(MACH_48);
		bus_req = 1'b0;

		// Handshake after the reset, then the bound assertion count
		bus_cycle("handshake", 16'h4000, 8'h11, 1'b1, 1'b0);
		bus_cycle("handshake", 16'h4000, 8'h00, 1'b0, 1'b0);
		check_value("handshake", "assertion failures", 32'(0),
			32'(zx_paging_top_i.handshake_chk_i.assert_fails));
		finish_test("handshake");

		$display("Total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before the tests finished, a bus handshake stalled");
		$display("Test FAILED");
		$finish;
	end

endmodule

// File: zx_paging_properties.sv
// Bus handshake assertions
`include "spectrum_defs.svh"

module zx_paging_properties (
	input logic clk_sys,
	input logic reset,
	input logic bus_req,
	input logic bus_ack,
	input logic mem_we
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int LAT = `ACK_LATENCY;

	// Count of failed assertions
	int assert_fails = 0;

	// Ack only ever follows a request
	ack_needs_req: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(bus_ack) |-> $past(bus_req))
	else begin
		$error("bus_ack rose without bus_req");
		assert_fails++;
	end

	// Fixed latency from the edge that takes req to the edge that raises ack
	ack_latency: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(bus_req) |=> ##LAT $rose(bus_ack))
	else begin
		$error("bus_ack did not rise at the fixed latency after bus_req");
		assert_fails++;
	end

	ack_release: assert property (@(posedge clk_sys) disable iff (reset)
		($fell(bus_req) && bus_ack) |=> !bus_ack)
	else begin
		$error("bus_ack did not fall one edge after bus_req fell");
		assert_fails++;
	end

	// Memory writes only inside an acknowledged cycle
	we_inside_ack: assert property (@(posedge clk_sys) disable iff (reset)
		mem_we |-> bus_ack)
	else begin
		$error("mem_we high while bus_ack low");
		assert_fails++;
	end

	reset_idle: assert property (@(posedge clk_sys)
		$fell(reset) |-> !bus_ack && !mem_we)
	else begin
		$error("bus_ack or mem_we high right after reset");
		assert_fails++;
	end

endmodule

bind zx_paging_top zx_paging_properties handshake_chk_i (
	.clk_sys (clk_sys),
	.reset   (reset),
	.bus_req (bus_req),
	.bus_ack (bus_ack),
	.mem_we  (mem_we)
);

// File: zx_paging_top.sv
// Spectrum paging core
`include "spectrum_defs.svh"

module zx_paging_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  spectrum_pkg::machine_t machine,

	// CPU bus, four-phase req/ack
	input  logic                   bus_req,
	output logic                   bus_ack,
	input  logic [`CPU_ADDR_W-1:0] bus_addr,
	input  logic [`CPU_DATA_W-1:0] bus_wdata,
	input  logic                   bus_wr,
	input  logic                   bus_io,
	output logic [`CPU_DATA_W-1:0] bus_rdata,

	// External memory
	output logic [`MEM_ADDR_W-1:0] mem_addr,
	output logic                   mem_we,
	input  logic [`CPU_DATA_W-1:0] mem_rdata,

	// Joysticks and keyboard
	input  logic [`JOY_W-1:0]      joy_0,
	input  logic [`JOY_W-1:0]      joy_1,
	input  logic [2:0]             joy_sel,
	input  logic [`KEY_ROW_W-1:0]  key_row
);
	logic [`CPU_DATA_W-1:0] kempston;
	logic [`KEY_ROW_W-1:0]  key_mask;

	// ========================================================================
	// Internal buses
	// ========================================================================

	cpu_cycle_if  cycle_bus ();
	page_state_if page_bus ();

	// ========================================================================
	// Units
	// ========================================================================

	paging_ports paging_ports_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.machine (machine),
		.cycle   (cycle_bus.sink),
		.pages   (page_bus.source)
	);

	joystick_port joystick_port_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cycle    (cycle_bus.sink),
		.joy_0    (joy_0),
		.joy_1    (joy_1),
		.joy_sel  (joy_sel),
		.kempston (kempston),
		.key_mask (key_mask)
	);

	bus_sequencer bus_sequencer_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus_req   (bus_req),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_wr    (bus_wr),
		.bus_io    (bus_io),
		.bus_ack   (bus_ack),
		.bus_rdata (bus_rdata),
		.mem_addr  (mem_addr),
		.mem_we    (mem_we),
		.mem_rdata (mem_rdata),
		.kempston  (kempston),
		.key_mask  (key_mask),
		.key_row   (key_row),
		.cycle     (cycle_bus.source),
		.pages     (page_bus.sink)
	);

endmodule

// File: bus_sequencer.sv
// CPU bus sequencer
`include "spectrum_defs.svh"

module bus_sequencer (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   bus_req,
	input  logic [`CPU_ADDR_W-1:0] bus_addr,
	input  logic [`CPU_DATA_W-1:0] bus_wdata,
	input  logic                   bus_wr,
	input  logic                   bus_io,
	output logic                   bus_ack,
	output logic [`CPU_DATA_W-1:0] bus_rdata,
	output logic [`MEM_ADDR_W-1:0] mem_addr,
	output logic                   mem_we,
	input  logic [`CPU_DATA_W-1:0] mem_rdata,
	input  logic [`CPU_DATA_W-1:0] kempston,
	input  logic [`KEY_ROW_W-1:0]  key_mask,
	input  logic [`KEY_ROW_W-1:0]  key_row,
	cpu_cycle_if.source            cycle,
	page_state_if.sink             pages
);
	import spectrum_pkg::*;

	localparam int              LAT      = `ACK_LATENCY;
	localparam int              CNT_W    = $clog2(LAT + 1);
	localparam logic [CNT_W-1:0] CNT_INIT = CNT_W'(LAT - 1);

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_WAIT,
		SEQ_ACK
	} seq_state_t;

	seq_state_t             seq_state;
	logic [CNT_W-1:0]       wait_cnt;
	logic                   req_take;
	logic                   ack_rise;
	page_state_t            page;
	logic [1:0]             region;
	logic                   map_rom;
	logic [`BANK_W-1:0]     map_bank;
	logic [`CPU_DATA_W-1:0] rdata_d;

	assign req_take = (seq_state == SEQ_IDLE) && bus_req;
	assign ack_rise = (seq_state == SEQ_WAIT) && (wait_cnt == '0);

	// ========================================================================
	// Four-phase handshake
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			seq_state    <= SEQ_IDLE;
			wait_cnt     <= '0;
			bus_ack      <= 1'b0;
			cycle.strobe <= 1'b0;
		end else begin
			cycle.strobe <= req_take;
			case (seq_state)
				SEQ_IDLE: begin
					if (bus_req) begin
						seq_state <= SEQ_WAIT;
						wait_cnt  <= CNT_INIT;
					end
				end
				SEQ_WAIT: begin
					if (wait_cnt == '0) begin
						seq_state <= SEQ_ACK;
						bus_ack   <= 1'b1;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				SEQ_ACK: begin
					if (!bus_req) begin
						seq_state <= SEQ_IDLE;
						bus_ack   <= 1'b0;
					end
				end
				default: seq_state <= SEQ_IDLE;
			endcase
		end
	end

	// Cycle capture and read data
	always_ff @(posedge clk_sys) begin
		if (req_take) begin
			cycle.addr  <= bus_addr;
			cycle.wdata <= bus_wdata;
			cycle.wr    <= bus_wr;
			cycle.io    <= bus_io;
		end
		if (ack_rise)
			bus_rdata <= rdata_d;
	end

	// ========================================================================
	// Address translation
	// ========================================================================

	assign page   = pages.state;
	assign region = cycle.addr[15:14];

	always_comb begin
		map_rom  = 1'b0;
		map_bank = page.bank;
		if (page.special_en) begin
			// All-RAM layouts of the +3
			case (region)
				2'd0: map_bank = {3'b000, |page.special_cfg, 2'b00};
				2'd1: map_bank = {3'b000, |page.special_cfg, &page.special_cfg, 1'b1};
				2'd2: map_bank = {3'b000, |page.special_cfg, 2'b10};
				default: map_bank = {3'b000,
					~page.special_cfg[1] & page.special_cfg[0], 2'b11};
			endcase
		end else begin
			case (region)
				2'd0: begin
					map_rom  = 1'b1;
					map_bank = {{(`BANK_W - `ROM_SEL_W){1'b0}}, page.rom};
				end
				2'd1: map_bank = `BANK_W'(5);
				2'd2: map_bank = `BANK_W'(2);
				default: map_bank = page.bank;
			endcase
		end
	end

	assign mem_addr = {map_rom, map_bank, cycle.addr[13:0]};

	// ROM only appears outside special mode, so this blocks ROM writes
	assign mem_we = bus_ack && cycle.wr && !cycle.io && !map_rom;

	// Kempston is checked before the keyboard rule
	always_comb begin
		if (cycle.wr)
			rdata_d = '1;
		else if (!cycle.io)
			rdata_d = mem_rdata;
		else if (cycle.addr[7:0] == `PORT_KEMPSTON_LO)
			rdata_d = kempston;
		else if (!cycle.addr[0])
			rdata_d = {{(`CPU_DATA_W - `KEY_ROW_W){1'b1}}, key_row & key_mask};
		else
			rdata_d = '1;
	end

endmodule

// File: joystick_port.sv
// Joystick port mapping
`include "spectrum_defs.svh"

module joystick_port (
	input  logic                   clk_sys,
	input  logic                   reset,
	cpu_cycle_if.sink              cycle,
	input  logic [`JOY_W-1:0]      joy_0,
	input  logic [`JOY_W-1:0]      joy_1,
	input  logic [2:0]             joy_sel,
	output logic [`CPU_DATA_W-1:0] kempston,
	output logic [`KEY_ROW_W-1:0]  key_mask
);
	// Stick bit positions
	localparam int J_RIGHT = 0;
	localparam int J_LEFT  = 1;
	localparam int J_DOWN  = 2;
	localparam int J_UP    = 3;
	localparam int J_FIRE  = 4;

	logic [`JOY_W-1:0]     joy_0_q;
	logic [`JOY_W-1:0]     joy_1_q;
	logic [`JOY_W-1:0]     joy_any;
	logic [`KEY_ROW_W-1:0] sinclair_1;
	logic [`KEY_ROW_W-1:0] sinclair_2;
	logic [`KEY_ROW_W-1:0] cursor_60;
	logic [`KEY_ROW_W-1:0] cursor_15;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joy_0_q <= '0;
			joy_1_q <= '0;
		end else begin
			joy_0_q <= joy_0;
			joy_1_q <= joy_1;
		end
	end

	assign joy_any = joy_0_q | joy_1_q;

	// Kempston only when no key mapping is chosen
	assign kempston = (joy_sel == 3'b000) ?
		{{(`CPU_DATA_W - `JOY_W){1'b0}}, joy_any} : '0;

	// Sinclair I on keys 6 7 8 9 0 (bits 4..0 are keys 6..0)
	assign sinclair_1 = {5{joy_sel[0]}} & {joy_0_q[J_LEFT], joy_0_q[J_RIGHT],
		joy_0_q[J_DOWN], joy_0_q[J_UP], joy_0_q[J_FIRE]};

	// Sinclair II on keys 1 2 3 4 5 (bits 0..4 are keys 1..5)
	assign sinclair_2 = {5{joy_sel[1]}} & {joy_1_q[J_FIRE], joy_1_q[J_UP],
		joy_1_q[J_DOWN], joy_1_q[J_RIGHT], joy_1_q[J_LEFT]};

	// Cursor keys 6 7 8 with fire on 0, left is key 5 in the other row
	assign cursor_60 = {5{joy_sel[2]}} & {joy_any[J_DOWN], joy_any[J_UP],
		joy_any[J_RIGHT], 1'b0, joy_any[J_FIRE]};
	assign cursor_15 = {5{joy_sel[2]}} & {joy_any[J_LEFT], 4'b0000};

	// Active low, only for the rows addressed by A12 and A11
	assign key_mask = ({5{cycle.addr[12]}} | ~(sinclair_1 | cursor_60)) &
		({5{cycle.addr[11]}} | ~(sinclair_2 | cursor_15));

endmodule

// File: paging_ports.sv
// Paging port decode and registers
`include "spectrum_defs.svh"

module paging_ports (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  spectrum_pkg::machine_t machine,
	cpu_cycle_if.sink              cycle,
	page_state_if.source           pages
);
	import spectrum_pkg::*;

	// ROM index of the 48K BASIC image
	localparam logic [`ROM_SEL_W-1:0] ROM_48K = 2'd1;

	machine_t    mach_q;
	port_7ffd_u  reg_7ffd;
	logic [2:0]  reg_1ffd;
	logic        eff7_compat;
	logic        is_48;
	logic        is_plus3;
	logic        is_p1024;
	logic        ext_on;
	logic        lock_on;
	logic        page_disable;
	logic        io_write;
	logic        hit_7ffd;
	logic        hit_1ffd;
	logic        hit_eff7;
	page_state_t state_d;

	assign is_48    = (mach_q == MACH_48);
	assign is_plus3 = (mach_q == MACH_PLUS3);
	assign is_p1024 = (mach_q == MACH_P1024);

	// Pentagon extension until EFF7 bit 2 selects 128K compatibility
	assign ext_on = is_p1024 && !eff7_compat;

	// In extended mode bit 5 is a bank bit, not the lock
	assign lock_on      = reg_7ffd.std.lock && (!is_p1024 || eff7_compat);
	assign page_disable = is_48 || lock_on;

	// ========================================================================
	// Port decode
	// ========================================================================

	assign io_write = cycle.strobe && cycle.io && cycle.wr;

	always_comb begin
		if (is_plus3)
			hit_7ffd = (cycle.addr & `PORT_7FFD_P3_MASK) == `PORT_7FFD_P3_MATCH;
		else
			hit_7ffd = (cycle.addr & `PORT_7FFD_MASK) == `PORT_7FFD_MATCH;
	end

	assign hit_1ffd = (cycle.addr & `PORT_1FFD_MASK) == `PORT_1FFD_MATCH;
	assign hit_eff7 = (cycle.addr & `PORT_EFF7_MASK) == `PORT_EFF7_MATCH;

	// ========================================================================
	// Registers
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mach_q      <= machine;
			reg_7ffd    <= '0;
			reg_1ffd    <= '0;
			eff7_compat <= 1'b0;
		end else if (io_write) begin
			if (hit_7ffd && !page_disable)
				reg_7ffd <= cycle.wdata;
			// 1FFD exists only on the +3 and obeys the same lock
			if (hit_1ffd && is_plus3 && !page_disable)
				reg_1ffd <= cycle.wdata[2:0];
			if (hit_eff7 && is_p1024)
				eff7_compat <= cycle.wdata[2];
		end
	end

	// Paging state
	always_comb begin
		state_d.bank = {{(`BANK_W - 3){1'b0}}, reg_7ffd.std.bank_lo};
		if (ext_on)
			state_d.bank = {reg_7ffd.p1024.ext_bank_mid, reg_7ffd.p1024.ext_bank_hi,
				reg_7ffd.std.bank_lo};

		case (mach_q)
			MACH_48:    state_d.rom = ROM_48K;
			MACH_PLUS3: state_d.rom = {reg_1ffd[2], reg_7ffd.std.rom_hi};
			default:    state_d.rom = {1'b0, reg_7ffd.std.rom_hi};
		endcase

		state_d.special_en  = reg_1ffd[0];
		state_d.special_cfg = reg_1ffd[2:1];
		state_d.disabled    = page_disable;
	end

	assign pages.state   = state_d;
	assign pages.machine = mach_q;
	assign pages.screen  = reg_7ffd.std.screen;
	assign pages.locked  = lock_on;

endmodule

// File: page_state_if.sv
// Paging state
interface page_state_if;
	import spectrum_pkg::*;

	page_state_t state;
	// Machine as latched during reset
	machine_t    machine;
	logic        screen;
	logic        locked;

	modport source (
		output state,
		output machine,
		output screen,
		output locked
	);

	modport sink (
		input state,
		input machine,
		input screen,
		input locked
	);
endinterface

// File: cpu_cycle_if.sv
// Decoded CPU cycle
`include "spectrum_defs.svh"

interface cpu_cycle_if;
	logic [`CPU_ADDR_W-1:0] addr;
	logic [`CPU_DATA_W-1:0] wdata;
	logic                   wr;
	logic                   io;
	// High for one clock right after the request is taken
	logic                   strobe;

	modport source (
		output addr,
		output wdata,
		output wr,
		output io,
		output strobe
	);

	modport sink (
		input addr,
		input wdata,
		input wr,
		input io,
		input strobe
	);
endinterface

// File: spectrum_pkg.sv
// Spectrum paging types
`include "spectrum_defs.svh"

package spectrum_pkg;

	// Machine picked at reset
	typedef enum logic [1:0] {
		MACH_48    = 2'd0,
		MACH_128   = 2'd1,
		MACH_PLUS3 = 2'd2,
		MACH_P1024 = 2'd3
	} machine_t;

	// Standard 128K layout of the 7FFD byte
	typedef struct packed {
		logic [1:0] spare;
		logic       lock;
		logic       rom_hi;
		logic       screen;
		logic [2:0] bank_lo;
	} port_7ffd_std_t;

	// Pentagon 1024 reads the top three bits as extra bank bits
	typedef struct packed {
		logic [1:0] ext_bank_hi;
		logic       ext_bank_mid;
		logic [4:0] rest;
	} port_7ffd_p1024_t;

	typedef union packed {
		port_7ffd_std_t   std;
		port_7ffd_p1024_t p1024;
	} port_7ffd_u;

	// Paging state seen by the address translator
	typedef struct packed {
		logic [`BANK_W-1:0]    bank;
		logic [`ROM_SEL_W-1:0] rom;
		logic                  special_en;
		logic [1:0]            special_cfg;
		logic                  disabled;
	} page_state_t;

endpackage

// File: spectrum_defs.svh
// Spectrum paging core constants
`ifndef SPECTRUM_DEFS_SVH
`define SPECTRUM_DEFS_SVH

// Bus and memory widths
`define CPU_ADDR_W 16
`define CPU_DATA_W 8

// Physical address: bit 20 ROM select, 19:14 bank, 13:0 offset
`define MEM_ADDR_W 21
`define BANK_W     6
`define ROM_SEL_W  2

// Joystick bits are right, left, down, up, fire from bit 0 upward
`define JOY_W      5
`define KEY_ROW_W  5

// 7FFD decodes on A15 and A1 low
`define PORT_7FFD_MASK     16'h8002
`define PORT_7FFD_MATCH    16'h0000
// The +3 also needs A14 high so 1FFD does not alias onto 7FFD
`define PORT_7FFD_P3_MASK  16'hC002
`define PORT_7FFD_P3_MATCH 16'h4000

// 1FFD decodes on A15..A12 = 0001 and A1 low
`define PORT_1FFD_MASK     16'hF002
`define PORT_1FFD_MATCH    16'h1000

// EFF7 decodes on A15..A12 = 1110 and A3 low
`define PORT_EFF7_MASK     16'hF008
`define PORT_EFF7_MATCH    16'hE000

// Kempston port, low address byte
`define PORT_KEMPSTON_LO   8'h1F

// Rising clock edges from req sampled to ack
`define ACK_LATENCY 2

`endif
